// ==== cu_edge_data_write_control.sv ====
/*
 * Edge data write control
 * Turns each accepted edge word into one write command and two data beats,
 * byte swapped into its slot, over two register stages
 */

module cu_edge_data_write_control #(
	parameter logic [7:0] CU_ID = 8'd1
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     write_enable,
	input  cu_pkg::wed_config_t      wed_config,
	input  cu_pkg::edge_data_write_t edge_data_write,
	output cu_pkg::write_command_t   write_command,
	output cu_pkg::write_data_beat_t write_data_0,
	output cu_pkg::write_data_beat_t write_data_1
);

	logic                     enable_q;
	logic                     accept;
	cu_pkg::wed_config_t      cfg_q;
	cu_pkg::command_tag_t     tag_next;
	cu_pkg::data_word_u       swapped;
	logic [cu_pkg::BEAT_BITS-1:0] slot_data;
	cu_pkg::write_command_t   cmd_next;
	cu_pkg::write_data_beat_t beat_next;

	// Stage valids
	logic                     valid_s1;
	logic                     valid_s2;
	// Stage payloads
	cu_pkg::write_command_t   cmd_s1;
	cu_pkg::write_command_t   cmd_s2;
	cu_pkg::write_data_beat_t beat_s1;
	cu_pkg::write_data_beat_t beat_s2;

	////////////////////////////////////////
	// Enable and config
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_q <= 1'b0;
		end else begin
			enable_q <= write_enable;
		end
	end

	// Config is steady by the time enable_q rises
	always_ff @(posedge clock) begin
		if (write_enable) begin
			cfg_q <= wed_config;
		end
	end

	// Words outside the enable window are dropped
	assign accept = edge_data_write.valid && enable_q;

	////////////////////////////////////////
	// Format
	////////////////////////////////////////

	always_comb begin
		tag_next                  = '0;
		tag_next.cu_id            = CU_ID;
		tag_next.slot_offset      = edge_data_write.index[cu_pkg::SLOT_BITS-1:0];
		tag_next.write_graph_data = 1'b1;

		swapped = cu_pkg::swap_bytes(edge_data_write.data);

		// Only the word's own slot carries data
		slot_data = '0;
		slot_data[tag_next.slot_offset*cu_pkg::DATA_SIZE_WRITE_BITS +:
			cu_pkg::DATA_SIZE_WRITE_BITS] = swapped.value;
	end

	always_comb begin
		cmd_next.valid   = accept;
		cmd_next.command = cfg_q.mode_ms ? cu_pkg::WRITE_MS : cu_pkg::WRITE_NA;
		// Byte address of the word
		cmd_next.address = cfg_q.base_address +
			(64'(edge_data_write.index) << $clog2(cu_pkg::DATA_SIZE_WRITE));
		cmd_next.size    = 8'(cu_pkg::DATA_SIZE_WRITE);
		cmd_next.tag     = tag_next;

		beat_next.valid = accept;
		beat_next.tag   = tag_next;
		beat_next.data  = slot_data;
	end

	////////////////////////////////////////
	// Stage 1
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid_s1 <= 1'b0;
		end else begin
			valid_s1 <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			cmd_s1  <= cmd_next;
			beat_s1 <= beat_next;
		end
	end

	////////////////////////////////////////
	// Stage 2
	////////////////////////////////////////

	// Runs freely so the last word drains after enable drops
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid_s2 <= 1'b0;
		end else begin
			valid_s2 <= valid_s1;
		end
	end

	always_ff @(posedge clock) begin
		if (valid_s1) begin
			cmd_s2  <= cmd_s1;
			beat_s2 <= beat_s1;
		end
	end

	// Both beats carry the same slot data and tag
	always_comb begin
		write_command       = cmd_s2;
		write_command.valid = valid_s2;
		write_data_0        = beat_s2;
		write_data_0.valid  = valid_s2;
		write_data_1        = beat_s2;
		write_data_1.valid  = valid_s2;
	end

	// Every output word was accepted while the FSM still held the path open
	a_valid_needs_enable: assert property (@(posedge clock) disable iff (!rstn)
		write_command.valid |-> $past(write_enable, 2))
		else $error("write command without enable two cycles earlier");

endmodule

// ==== cu_edge_write.f ====
+incdir+.
cu_pkg.sv
cu_write_tracker.sv
cu_edge_write_fsm.sv
cu_edge_data_write_control.sv
cu_edge_write_top.sv
tb_cu_edge_write.sv

// ==== cu_edge_write_fsm.sv ====
/*
 * Edge write job FSM
 * Starts a job, opens the write path until every write is issued,
 * then waits for the last response and pulses done
 */

module cu_edge_write_fsm (
	input  logic                clock,
	input  logic                rstn,
	input  logic                start,
	input  cu_pkg::wed_config_t wed_config,
	input  logic [31:0]         issued_count,
	input  logic                outstanding_zero,
	output logic                write_enable,
	output logic                job_clear,
	output logic                busy,
	output logic                done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ACTIVE,
		S_DRAIN,
		S_FINISH
	} state_t;

	state_t      state;
	logic [31:0] edge_count;

	// Start only counts when no job is running
	assign job_clear = start && !busy;

	////////////////////////////////////////
	// Job length
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (job_clear) begin
			edge_count <= wed_config.edge_count;
		end
	end

	////////////////////////////////////////
	// State machine
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= S_IDLE;
			busy         <= 1'b0;
			done         <= 1'b0;
			write_enable <= 1'b0;
		end else begin
			// Done is a single cycle pulse
			done <= 1'b0;
			case (state)
				S_IDLE, S_FINISH: begin
					// Finish also takes a new start right away
					if (job_clear) begin
						state        <= S_ACTIVE;
						busy         <= 1'b1;
						write_enable <= 1'b1;
					end else begin
						state <= S_IDLE;
					end
				end
				S_ACTIVE: begin
					// All writes issued, close the path
					if (issued_count == edge_count) begin
						state        <= S_DRAIN;
						write_enable <= 1'b0;
					end
				end
				S_DRAIN: begin
					// Wait for the last response
					if (outstanding_zero) begin
						state <= S_FINISH;
						busy  <= 1'b0;
						done  <= 1'b1;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Host must not restart a running job
	a_no_start_while_busy: assert property (@(posedge clock) disable iff (!rstn)
		start |-> !busy)
		else $error("start arrived while a job is running");

endmodule

// ==== cu_edge_write_top.sv ====
/*
 * Edge write path of one graph compute unit
 * Job FSM, write tracker and write control
 */

module cu_edge_write_top #(
	parameter logic [7:0] CU_ID = 8'd1
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     start,
	input  cu_pkg::wed_config_t      wed_config,
	input  cu_pkg::edge_data_write_t edge_data_write,
	input  logic                     write_response,
	output cu_pkg::write_command_t   write_command,
	output cu_pkg::write_data_beat_t write_data_0,
	output cu_pkg::write_data_beat_t write_data_1,
	output logic                     busy,
	output logic                     done
);

	// FSM to control and tracker
	logic        write_enable;
	logic        job_clear;
	// Tracker back to FSM
	logic [31:0] issued_count;
	logic        outstanding_zero;

	////////////////////////////////////////
	// Job control
	////////////////////////////////////////

	cu_edge_write_fsm u_fsm (
		.clock            (clock),
		.rstn             (rstn),
		.start            (start),
		.wed_config       (wed_config),
		.issued_count     (issued_count),
		.outstanding_zero (outstanding_zero),
		.write_enable     (write_enable),
		.job_clear        (job_clear),
		.busy             (busy),
		.done             (done)
	);

	// Each command out is one issue
	cu_write_tracker u_tracker (
		.clock            (clock),
		.rstn             (rstn),
		.job_clear        (job_clear),
		.issue            (write_command.valid),
		.write_response   (write_response),
		.issued_count     (issued_count),
		.outstanding_zero (outstanding_zero)
	);

	////////////////////////////////////////
	// Data path
	////////////////////////////////////////

	cu_edge_data_write_control #(
		.CU_ID (CU_ID)
	) u_control (
		.clock           (clock),
		.rstn            (rstn),
		.write_enable    (write_enable),
		.wed_config      (wed_config),
		.edge_data_write (edge_data_write),
		.write_command   (write_command),
		.write_data_0    (write_data_0),
		.write_data_1    (write_data_1)
	);

endmodule

// ==== cu_pkg.sv ====
/*
 * Graph compute unit edge write path, shared definitions
 * Sizes, write command codes, and the structs for config, edge words and bus beats
 */

package cu_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	// Bytes in one cacheline, split over two data beats
	localparam int CACHELINE_SIZE = 128;
	// One edge word on the write path
	localparam int DATA_SIZE_WRITE = 4;
	localparam int DATA_SIZE_WRITE_BITS = 32;
	// Word slots in a single 64 byte beat
	localparam int WORDS_PER_BEAT = 16;

	// Derived widths
	localparam int BEAT_BITS = (CACHELINE_SIZE / 2) * 8;
	localparam int SLOT_BITS = $clog2(WORDS_PER_BEAT);

	////////////////////////////////////////
	// Command codes
	////////////////////////////////////////

	typedef enum logic [1:0] {
		WRITE_NA = 2'b00,
		WRITE_MS = 2'b01
	} cmd_code_t;

	////////////////////////////////////////
	// Data words and job config
	////////////////////////////////////////

	// Edge value, seen either whole or byte by byte
	typedef union packed {
		logic [DATA_SIZE_WRITE_BITS-1:0] value;
		logic [DATA_SIZE_WRITE-1:0][7:0] bytes;
	} data_word_u;

	typedef struct packed {
		logic        valid;
		logic [31:0] index;
		data_word_u  data;
	} edge_data_write_t;

	// Held by the host for the whole job
	typedef struct packed {
		logic [63:0] base_address;
		logic [31:0] edge_count;
		logic        mode_ms;
	} wed_config_t;

	////////////////////////////////////////
	// Memory side
	////////////////////////////////////////

	typedef struct packed {
		logic [7:0]           cu_id;
		logic [SLOT_BITS-1:0] slot_offset;
		logic                 write_graph_data;
	} command_tag_t;

	typedef struct packed {
		logic         valid;
		cmd_code_t    command;
		logic [63:0]  address;
		logic [7:0]   size;
		command_tag_t tag;
	} write_command_t;

	typedef struct packed {
		logic                 valid;
		command_tag_t         tag;
		logic [BEAT_BITS-1:0] data;
	} write_data_beat_t;

	// Host word order to memory word order
	function automatic data_word_u swap_bytes(input data_word_u word);
		data_word_u swapped;
		for (int i = 0; i < DATA_SIZE_WRITE; i++) begin
			swapped.bytes[i] = word.bytes[DATA_SIZE_WRITE-1-i];
		end
		return swapped;
	endfunction

endpackage

// ==== cu_write_tracker.sv ====
/*
 * Write tracker
 * Counts writes issued in the job and writes still waiting for a response
 */

module cu_write_tracker (
	input  logic        clock,
	input  logic        rstn,
	input  logic        job_clear,
	input  logic        issue,
	input  logic        write_response,
	output logic [31:0] issued_count,
	output logic        outstanding_zero
);

	logic [31:0] outstanding;

	////////////////////////////////////////
	// Issued count
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issued_count <= '0;
		end else if (job_clear) begin
			// Fresh count per job
			issued_count <= '0;
		end else if (issue) begin
			issued_count <= issued_count + 32'd1;
		end
	end

	////////////////////////////////////////
	// Outstanding count
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			// Issue and response together cancel out
			case ({issue, write_response})
				2'b10: outstanding <= outstanding + 32'd1;
				2'b01: outstanding <= outstanding - 32'd1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	assign outstanding_zero = (outstanding == '0);

	// A response needs a write issued in an earlier cycle
	a_no_orphan_response: assert property (@(posedge clock) disable iff (!rstn)
		write_response |-> !outstanding_zero)
		else $error("write response with nothing outstanding");

	a_issued_no_wrap: assert property (@(posedge clock) disable iff (!rstn)
		(issue && !job_clear) |-> (issued_count != '1))
		else $error("issued count wrapped");

	a_outstanding_no_wrap: assert property (@(posedge clock) disable iff (!rstn)
		(issue && !write_response) |-> (outstanding != '1))
		else $error("outstanding count wrapped");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the edge write testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cu_edge_write -f cu_edge_write.f -o tb_cu_edge_write

output=$(./obj_dir/tb_cu_edge_write 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

// ==== tb_cu_edge_write_ref.svh ====
/*
 * Reference model for the edge write path
 * Expected command and data beat for one edge word, plus typed compare tasks
 */

`ifndef TB_CU_EDGE_WRITE_REF_SVH
`define TB_CU_EDGE_WRITE_REF_SVH

// Tag shared by the command and both beats
function automatic cu_pkg::command_tag_t expected_tag(input logic [31:0] index,
	input logic [7:0] cu_id);
	cu_pkg::command_tag_t tag;
	logic [31:0]          slot;
	slot                 = index % 32'd16;
	tag.cu_id            = cu_id;
	tag.slot_offset      = slot[3:0];
	tag.write_graph_data = 1'b1;
	return tag;
endfunction

function automatic cu_pkg::write_command_t expected_command(input logic [31:0] index,
	input cu_pkg::wed_config_t cfg, input logic [7:0] cu_id);
	cu_pkg::write_command_t cmd;
	cmd.valid   = 1'b1;
	cmd.command = cfg.mode_ms ? cu_pkg::WRITE_MS : cu_pkg::WRITE_NA;
	// Four bytes per edge word
	cmd.address = cfg.base_address + {32'd0, index} * 64'd4;
	cmd.size    = 8'd4;
	cmd.tag     = expected_tag(index, cu_id);
	return cmd;
endfunction

function automatic cu_pkg::write_data_beat_t expected_beat(input logic [31:0] index,
	input logic [31:0] value, input logic [7:0] cu_id);
	cu_pkg::write_data_beat_t beat;
	logic [31:0]              swapped;
	int                       slot;
	// Byte order reversed for memory
	swapped    = {value[7:0], value[15:8], value[23:16], value[31:24]};
	slot       = int'(index % 32'd16);
	beat.valid = 1'b1;
	beat.tag   = expected_tag(index, cu_id);
	beat.data  = '0;
	beat.data[slot*32 +: 32] = swapped;
	return beat;
endfunction

task automatic compare_command(input string name, input cu_pkg::write_command_t got,
	input cu_pkg::write_command_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("Fail %s got %h expected %h", name, got, exp);
	end
endtask

task automatic compare_beat(input string name, input cu_pkg::write_data_beat_t got,
	input cu_pkg::write_data_beat_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("Fail %s got %h expected %h", name, got, exp);
	end
endtask

`endif

// ==== tb_cu_edge_write.sv ====
/*
 * Testbench for the compute unit edge write path
 * Two jobs with random edge words, a random latency response model and a checker
 */

module tb_cu_edge_write;

	localparam logic [7:0] CU_ID = 8'd5;
	localparam int TIMEOUT_CYCLES = 2000;

	// One word sent to the DUT and the cycle it was sampled in
	typedef struct packed {
		logic [31:0]              cycle;
		cu_pkg::wed_config_t      cfg;
		cu_pkg::edge_data_write_t word;
	} expect_t;

	logic                     clock;
	logic                     rstn;
	logic                     start;
	cu_pkg::wed_config_t      wed_config;
	cu_pkg::edge_data_write_t edge_data_write;
	logic                     write_response;
	cu_pkg::write_command_t   write_command;
	cu_pkg::write_data_beat_t write_data_0;
	cu_pkg::write_data_beat_t write_data_1;
	logic                     busy;
	logic                     done;

	// Error counts
	int value_errors;
	int timeout_errors;
	int protocol_errors;

	int unsigned cycle_count;
	expect_t     expect_q[$];
	// Response due cycles, kept in rising order
	logic [31:0] due_q[$];
	logic [31:0] last_due;
	int unsigned job_edges;
	int unsigned cmd_total;
	int unsigned resp_total;
	int unsigned done_total;
	logic        busy_prev;

	`include "tb_cu_edge_write_ref.svh"

	cu_edge_write_top #(
		.CU_ID (CU_ID)
	) u_dut (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.wed_config      (wed_config),
		.edge_data_write (edge_data_write),
		.write_response  (write_response),
		.write_command   (write_command),
		.write_data_0    (write_data_0),
		.write_data_1    (write_data_1),
		.busy            (busy),
		.done            (done)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic finish_run();
		$display("Errors: value %0d, timeout %0d, protocol %0d",
			value_errors, timeout_errors, protocol_errors);
		if (value_errors + timeout_errors + protocol_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	task automatic wait_for_busy();
		int waited;
		waited = 0;
		while (!busy && waited < TIMEOUT_CYCLES) begin
			@(negedge clock);
			waited++;
		end
		if (!busy) begin
			$display("Timeout: busy never rose after start");
			timeout_errors++;
			finish_run();
		end
	endtask

	task automatic wait_for_done();
		int waited;
		waited = 0;
		while (!done && waited < TIMEOUT_CYCLES) begin
			@(negedge clock);
			waited++;
		end
		if (!done) begin
			$display("Timeout: done never pulsed for the running job");
			timeout_errors++;
			finish_run();
		end
	endtask

	// Nothing may move while no job runs
	task automatic check_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			if (busy || done || write_command.valid || write_data_0.valid ||
				write_data_1.valid) begin
				protocol_errors++;
				$display("Busy, done or an output strobe was active with no job running");
			end
			@(negedge clock);
		end
	endtask

	task automatic start_job(input cu_pkg::wed_config_t cfg);
		wed_config = cfg;
		start      = 1'b1;
		job_edges += cfg.edge_count;
		@(negedge clock);
		start = 1'b0;
		wait_for_busy();
		// Write path opens two cycles after busy
		repeat (2) @(negedge clock);
	endtask

	task automatic send_word(input logic [31:0] index, input logic [31:0] value);
		expect_t entry;
		edge_data_write.valid      = 1'b1;
		edge_data_write.index      = index;
		edge_data_write.data.value = value;
		entry.cycle = cycle_count + 1;
		entry.cfg   = wed_config;
		entry.word  = edge_data_write;
		expect_q.push_back(entry);
		@(negedge clock);
		edge_data_write.valid = 1'b0;
	endtask

	// Words while busy is low, none of them may come out
	task automatic send_dropped(input int count);
		for (int i = 0; i < count; i++) begin
			edge_data_write.valid      = 1'b1;
			edge_data_write.index      = $urandom;
			edge_data_write.data.value = $urandom;
			@(negedge clock);
		end
		edge_data_write.valid = 1'b0;
	endtask

	////////////////////////////////////////
	// Checker and response model
	////////////////////////////////////////

	always @(negedge clock) begin
		expect_t     entry;
		logic [31:0] due;
		if (rstn) begin
			if (write_command.valid || write_data_0.valid || write_data_1.valid) begin
				cmd_total++;
				// Response no earlier than the cycle after the tracker counts it
				due = cycle_count + 1 + ($urandom % 6);
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				due_q.push_back(due);
				if (expect_q.size() == 0) begin
					protocol_errors++;
					$display("Output strobe with no accepted edge word behind it");
				end else begin
					entry = expect_q.pop_front();
					// Strobe seen here is taken at the next rising edge
					if (cycle_count + 1 != entry.cycle + 2) begin
						value_errors++;
						$display("Fail write_command latency got %h expected %h",
							cycle_count + 1 - entry.cycle, 32'd2);
					end
					compare_command("write_command", write_command,
						expected_command(entry.word.index, entry.cfg, CU_ID));
					compare_beat("write_data_0", write_data_0,
						expected_beat(entry.word.index, entry.word.data.value, CU_ID));
					compare_beat("write_data_1", write_data_1,
						expected_beat(entry.word.index, entry.word.data.value, CU_ID));
				end
			end
			write_response = 1'b0;
			if (due_q.size() != 0 && due_q[0] <= cycle_count) begin
				void'(due_q.pop_front());
				write_response = 1'b1;
				resp_total++;
			end
			if (done) begin
				done_total++;
				if (busy || !busy_prev) begin
					protocol_errors++;
					$display("Busy did not fall in the cycle that done pulsed");
				end
				if (cmd_total != job_edges || resp_total != job_edges ||
					expect_q.size() != 0) begin
					protocol_errors++;
					$display("Done pulsed before all writes were issued and acknowledged");
				end
			end
			busy_prev = busy;
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		cu_pkg::wed_config_t cfg;
		logic [31:0]         index_base;
		clock           = 1'b0;
		rstn            = 1'b0;
		start           = 1'b0;
		wed_config      = '0;
		edge_data_write = '0;
		write_response  = 1'b0;
		value_errors    = 0;
		timeout_errors  = 0;
		protocol_errors = 0;
		cycle_count     = 0;
		last_due        = '0;
		job_edges       = 0;
		cmd_total       = 0;
		resp_total      = 0;
		done_total      = 0;
		busy_prev       = 1'b0;
		void'($urandom(32'h73c8));

		repeat (16) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// Quiet after reset, early words dropped
		check_idle(8);
		send_dropped(4);
		check_idle(8);

		// Job 1, random indices with gaps, WRITE_NA
		cfg.base_address = {$urandom, $urandom};
		cfg.edge_count   = 32'd20;
		cfg.mode_ms      = 1'b0;
		start_job(cfg);
		for (int i = 0; i < 20; i++) begin
			send_word($urandom % 4096, $urandom);
			repeat ($urandom % 3) @(negedge clock);
		end
		wait_for_done();
		@(negedge clock);
		check_idle(6);
		send_dropped(5);
		check_idle(8);

		// Job 2, back to back over every slot, WRITE_MS
		cfg.base_address = {$urandom, $urandom};
		cfg.edge_count   = 32'd20;
		cfg.mode_ms      = 1'b1;
		start_job(cfg);
		index_base = ($urandom % 256) << 4;
		for (int i = 0; i < 20; i++) begin
			send_word(index_base + i, $urandom);
		end
		wait_for_done();
		@(negedge clock);
		check_idle(6);
		send_dropped(5);
		check_idle(10);

		if (done_total != 2) begin
			protocol_errors++;
			$display("Done pulsed %0d times over two jobs", done_total);
		end
		finish_run();
	end

endmodule
